// File: Makefile
# Verilator build and run of the AHB-Lite memory testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= ahb_mem_tb
SEED      ?= 32'hcc022b5d
FILELIST  ?= ahb_mem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP SEED FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  "-GSEED=$(SEED)" --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: ahb_mem.f
+incdir+hdl
hdl/ahb_mem_pkg.sv
hdl/ahb_bank_if.sv
hdl/ahb_addr_decoder.sv
hdl/ahb_mem_bank.sv
hdl/ahb_resp_mux.sv
hdl/ahb_mem_top.sv
testbench/ahb_mem_chk.sv
testbench/ahb_mem_tb.sv

// File: hdl/ahb_addr_decoder.sv
// AHB-Lite address-phase decoder
// Splits HADDR into bank, index and offset and selects one bank per transfer
`timescale 1ns/100ps
`include "ahb_mem_settings.svh"

module ahb_addr_decoder
  import ahb_mem_pkg::*;
(
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic [31:0]                haddr,
  input  htrans_e                    htrans,
  input  hsize_e                     hsize,
  input  logic                       hwrite,
  input  logic                       hprot0,
  input  logic                       hsel,
  input  logic                       hready,
  ahb_bank_if.dec                    bank [`AHB_MEM_BANKS],
  output logic                       err_req,
  output logic [`AHB_MEM_BANK_W-1:0] resp_bank
);

  localparam int BANK_W = `AHB_MEM_BANK_W;

  ahb_addr_u addr_u;
  logic      active;
  logic      in_range;
  logic      take;

  assign addr_u.raw = haddr;

  // Only NONSEQ and SEQ carry data, BUSY is treated like IDLE
  assign active   = (htrans == NONSEQ) || (htrans == SEQ);
  assign in_range = (addr_u.fields.upper == '0);

  // The address phase completes on the edge that ends this cycle
  assign take = hsel & hready;

  assign err_req = take & active & ~in_range;

  for (genvar i = 0; i < `AHB_MEM_BANKS; i++) begin : g_sel
    assign bank[i].sel    = take & in_range & (addr_u.fields.bank == BANK_W'(i));
    assign bank[i].addr   = {addr_u.fields.index, addr_u.fields.offset};
    assign bank[i].size   = hsize;
    assign bank[i].write  = hwrite;
    assign bank[i].prot   = hprot0;
    assign bank[i].active = active;
  end

  // Bank that owns the coming data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      resp_bank <= '0;
    end else if (take) begin
      resp_bank <= addr_u.fields.bank;
    end
  end

endmodule

// File: hdl/ahb_bank_if.sv
// Request and response signals between the decoder, one memory bank and the mux
// One instance per bank; the top level drives wdata and ready from the bus
`timescale 1ns/100ps
`include "ahb_mem_settings.svh"

interface ahb_bank_if
  import ahb_mem_pkg::*;
();

  // Address phase, from the decoder
  logic                        sel;
  logic [`AHB_MEM_IDX_W+2:0]   addr;
  hsize_e                      size;
  logic                        write;
  logic                        prot;
  logic                        active;

  // Data phase, straight from the bus
  logic [63:0]                 wdata;
  logic                        ready;

  // Bank response
  logic [63:0]                 rdata;
  logic                        readyout;

  modport dec (output sel, addr, size, write, prot, active);

  modport bank (
    input  sel, addr, size, write, prot, active, wdata, ready,
    output rdata, readyout
  );

  modport mux (input rdata, readyout);

endinterface

// File: hdl/ahb_mem_bank.sv
// One 64-bit memory bank behind the AHB-Lite decoder
// Writes bytes under a size/offset strobe and stalls the data phase a fixed
// number of cycles, chosen by HPROT[0]
`timescale 1ns/100ps
`include "ahb_mem_settings.svh"

module ahb_mem_bank
  import ahb_mem_pkg::*;
(
  input logic      HCLK,
  input logic      HRESETn,
  ahb_bank_if.bank port
);

  localparam int IDX_W    = `AHB_MEM_IDX_W;
  localparam int WAIT_MAX = (`AHB_MEM_DATA_WAIT > `AHB_MEM_INSTR_WAIT) ?
                            `AHB_MEM_DATA_WAIT : `AHB_MEM_INSTR_WAIT;
  localparam int CNT_W    = (WAIT_MAX > 0) ? $clog2(WAIT_MAX + 1) : 1;

  localparam logic [CNT_W-1:0] DATA_WAIT  = CNT_W'(`AHB_MEM_DATA_WAIT);
  localparam logic [CNT_W-1:0] INSTR_WAIT = CNT_W'(`AHB_MEM_INSTR_WAIT);

  logic [63:0]      mem [`AHB_MEM_BANK_WORDS];
  logic [IDX_W-1:0] idx_q;
  logic [2:0]       off_q;
  hsize_e           size_q;
  logic             write_q;
  logic [CNT_W-1:0] wait_cnt;
  logic [7:0]       strb;
  logic             start;

  // A real transfer to this bank is starting its data phase
  assign start = port.sel & port.active;

  // Latch the request for the data phase
  always_ff @(posedge HCLK) begin
    if (port.sel) begin
      idx_q  <= port.addr[IDX_W+2:3];
      off_q  <= port.addr[2:0];
      size_q <= port.size;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      write_q  <= 1'b0;
      wait_cnt <= '0;
    end else begin
      // Any completing data phase clears a pending write, so it commits once
      if (port.ready) begin
        write_q <= start & port.write;
      end
      if (start) begin
        wait_cnt <= port.prot ? DATA_WAIT : INSTR_WAIT;
      end else if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end
  end

  // Byte lanes touched by the transfer, aligned to its size
  always_comb begin
    case (size_q)
      BYTE:    strb = 8'h01 << off_q;
      HALF:    strb = 8'h03 << {off_q[2:1], 1'b0};
      WORD:    strb = 8'h0f << {off_q[2], 2'b00};
      default: strb = 8'hff;
    endcase
  end

  // Write data is valid on the edge that ends the data phase
  always_ff @(posedge HCLK) begin
    if (write_q && port.ready) begin
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) begin
          mem[idx_q][b*8 +: 8] <= port.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Combinational read, so a write just before is already visible
  assign port.rdata    = mem[idx_q];
  assign port.readyout = (wait_cnt == '0);

endmodule

// File: hdl/ahb_mem_pkg.sv
// Shared types for the AHB-Lite memory subsystem
// Modules import what they need with a wildcard import in their header
`include "ahb_mem_settings.svh"

package ahb_mem_pkg;

  // Bus address, read either as a flat word or as memory fields
  // A nonzero upper field lies outside the memory
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [31-`AHB_MEM_BANK_W-`AHB_MEM_IDX_W-3:0] upper;
      logic [`AHB_MEM_BANK_W-1:0]                   bank;
      logic [`AHB_MEM_IDX_W-1:0]                    index;
      logic [2:0]                                   offset;
    } fields;
  } ahb_addr_u;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HALF  = 3'b001,
    WORD  = 3'b010,
    DWORD = 3'b011
  } hsize_e;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

endpackage

// File: hdl/ahb_mem_settings.svh
// Build-time settings for the AHB-Lite memory subsystem
// Include this wherever bank geometry or wait-state counts are needed
`ifndef AHB_MEM_SETTINGS_SVH
`define AHB_MEM_SETTINGS_SVH

// Number of memory banks, a power of two
`define AHB_MEM_BANKS 4

// 64-bit words held by each bank, a power of two
`define AHB_MEM_BANK_WORDS 64

// Fixed wait states per data phase, chosen by HPROT[0]
`define AHB_MEM_DATA_WAIT 2
`define AHB_MEM_INSTR_WAIT 0

// Widths of the word index and the bank number
`define AHB_MEM_IDX_W ($clog2(`AHB_MEM_BANK_WORDS))
`define AHB_MEM_BANK_W ($clog2(`AHB_MEM_BANKS))

`endif

// File: hdl/ahb_mem_top.sv
// Top level of the 64-bit AHB-Lite on-chip memory
// Plain slave port; HREADY is expected to come back from HREADYOUT or the
// system's ready mux
`timescale 1ns/100ps
`include "ahb_mem_settings.svh"

module ahb_mem_top
  import ahb_mem_pkg::*;
(
  input  logic        HCLK,
  input  logic        HRESETn,
  input  logic        HSEL,
  input  logic [31:0] HADDR,
  input  logic [1:0]  HTRANS,
  input  logic [2:0]  HSIZE,
  input  logic        HWRITE,
  input  logic [3:0]  HPROT,
  input  logic [63:0] HWDATA,
  input  logic        HREADY,
  output logic [63:0] HRDATA,
  output logic        HREADYOUT,
  output logic        HRESP
);

  logic                       err_req;
  logic [`AHB_MEM_BANK_W-1:0] resp_bank;
  hresp_e                     resp_code;

  ahb_bank_if bank_if [`AHB_MEM_BANKS] ();

  ahb_addr_decoder dec0 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .haddr     (HADDR),
    .htrans    (htrans_e'(HTRANS)),
    .hsize     (hsize_e'(HSIZE)),
    .hwrite    (HWRITE),
    .hprot0    (HPROT[0]),
    .hsel      (HSEL),
    .hready    (HREADY),
    .bank      (bank_if),
    .err_req   (err_req),
    .resp_bank (resp_bank)
  );

  // Every bank sees the write data and the bus ready directly
  for (genvar i = 0; i < `AHB_MEM_BANKS; i++) begin : g_bank
    assign bank_if[i].wdata = HWDATA;
    assign bank_if[i].ready = HREADY;

    ahb_mem_bank bank0 (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .port    (bank_if[i])
    );
  end

  ahb_resp_mux mux0 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .bank      (bank_if),
    .err_req   (err_req),
    .resp_bank (resp_bank),
    .hrdata    (HRDATA),
    .hreadyout (HREADYOUT),
    .hresp     (resp_code)
  );

  assign HRESP = resp_code;

endmodule

// File: hdl/ahb_resp_mux.sv
// Response side of the AHB-Lite memory subsystem
// Returns the owning bank's read data and ready, or the two-cycle ERROR
// response for an address outside the memory
`timescale 1ns/100ps
`include "ahb_mem_settings.svh"

module ahb_resp_mux
  import ahb_mem_pkg::*;
(
  input  logic                       HCLK,
  input  logic                       HRESETn,
  ahb_bank_if.mux                    bank [`AHB_MEM_BANKS],
  input  logic                       err_req,
  input  logic [`AHB_MEM_BANK_W-1:0] resp_bank,
  output logic [63:0]                hrdata,
  output logic                       hreadyout,
  output hresp_e                     hresp
);

  logic [63:0]               rdata_all [`AHB_MEM_BANKS];
  logic [`AHB_MEM_BANKS-1:0] readyout_all;
  logic                      err_first;
  logic                      err_second;

  // Interface arrays take only constant indices, so gather into plain arrays
  for (genvar i = 0; i < `AHB_MEM_BANKS; i++) begin : g_gather
    assign rdata_all[i]    = bank[i].rdata;
    assign readyout_all[i] = bank[i].readyout;
  end

  // ERROR sequencer: first cycle stalls the bus, second one completes it
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      err_first  <= 1'b0;
      err_second <= 1'b0;
    end else begin
      err_first  <= err_req;
      err_second <= err_first;
    end
  end

  // A bank outside its data phase has no wait pending, so idle cycles see ready
  always_comb begin
    hrdata    = rdata_all[resp_bank];
    hreadyout = readyout_all[resp_bank];
    hresp     = OKAY;
    if (err_first) begin
      hreadyout = 1'b0;
      hresp     = ERROR;
    end else if (err_second) begin
      hreadyout = 1'b1;
      hresp     = ERROR;
    end
  end

endmodule

// File: testbench/ahb_mem_chk.sv
// Protocol assertions on the ports of the AHB-Lite memory top level
// Bound to ahb_mem_top from the testbench
`timescale 1ns/100ps

module ahb_mem_chk (
  input logic        HCLK,
  input logic        HRESETn,
  input logic        hsel,
  input logic [1:0]  htrans,
  input logic        hwrite,
  input logic        hready,
  input logic [63:0] hrdata,
  input logic        hreadyout,
  input logic        hresp
);

  logic rd_dphase;
  int   fail_cnt = 0;

  // A read owns the data phase that follows its completed address phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      rd_dphase <= 1'b0;
    end else if (hready) begin
      rd_dphase <= hsel & htrans[1] & ~hwrite;
    end
  end

  // First ERROR cycle stalls the bus, the second one completes the transfer
  a_err_second: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (hresp && !hreadyout) |=> (hresp && hreadyout))
    else begin
      fail_cnt++;
      $error("ERROR response did not end with HREADYOUT high");
    end

  a_okay_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (hreadyout && !$past(hresp && !hreadyout)) |-> !hresp)
    else begin
      fail_cnt++;
      $error("HRESP not OKAY on a completing transfer outside an error");
    end

  a_rdata_known: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (rd_dphase && hreadyout && !hresp) |-> !$isunknown(hrdata))
    else begin
      fail_cnt++;
      $error("HRDATA holds unknown bits when a read completes");
    end

endmodule

// File: testbench/ahb_mem_tb.sv
// Testbench for the AHB-Lite memory subsystem
// Applies a table of directed transfers, then a random sweep checked against a
// byte model, and checks read data, HRESP and the wait states of every transfer
`timescale 1ns/100ps
`include "ahb_mem_settings.svh"

module ahb_mem_tb
  import ahb_mem_pkg::*;
#(
  parameter logic [31:0] SEED = 32'hcc022b5d
);

  localparam int   WORDS = `AHB_MEM_BANKS * `AHB_MEM_BANK_WORDS;
  localparam logic WR    = 1'b1;
  localparam logic RD    = 1'b0;
  localparam logic DAT   = 1'b1;
  localparam logic INS   = 1'b0;
  localparam logic ERR   = 1'b1;
  localparam logic NOERR = 1'b0;

  typedef struct {
    logic [1:0]  trans;
    logic        write;
    logic [31:0] addr;
    logic [2:0]  size;
    logic        prot;
    logic [63:0] wdata;
    logic [63:0] rdata;
    logic        err;
  } xfer_t;

  logic        HCLK;
  logic        HRESETn;
  logic        hsel;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic [2:0]  hsize;
  logic        hwrite;
  logic [3:0]  hprot;
  logic [63:0] hwdata;
  logic        hready;
  logic [63:0] hrdata;
  logic        hreadyout;
  logic        hresp;

  xfer_t      xfers [$];
  logic [7:0] model [WORDS*8];
  integer     seed;
  int         cycles = 0;
  int         cycle_limit = 0;

  // Single slave on the bus, so its own ready closes the loop
  assign hready = hreadyout;

  ahb_mem_top dut0 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (hsel),
    .HADDR     (haddr),
    .HTRANS    (htrans),
    .HSIZE     (hsize),
    .HWRITE    (hwrite),
    .HPROT     (hprot),
    .HWDATA    (hwdata),
    .HREADY    (hready),
    .HRDATA    (hrdata),
    .HREADYOUT (hreadyout),
    .HRESP     (hresp)
  );

  bind ahb_mem_top ahb_mem_chk chk0 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (HSEL),
    .htrans    (HTRANS),
    .hwrite    (HWRITE),
    .hready    (HREADY),
    .hrdata    (HRDATA),
    .hreadyout (HREADYOUT),
    .hresp     (HRESP)
  );

  initial begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  always @(posedge HCLK) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: transfers still pending after %0d cycles", cycle_limit);
      $display("Something failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  always @(negedge HCLK) begin
    if (dut0.chk0.fail_cnt != 0) begin
      $display("Protocol assertion failed at %0t ns in the bound checker", $time);
      $display("Something failed");
      $fatal(1, "Stopped at the first assertion failure");
    end
  end

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic add_xfer(input logic [1:0] trans, input logic write, input logic [31:0] addr,
                          input logic [2:0] size, input logic prot, input logic [63:0] wdata,
                          input logic [63:0] rdata, input logic err);
    xfers.push_back('{trans, write, addr, size, prot, wdata, rdata, err});
  endtask

  // An ERROR response stalls one cycle, IDLE and BUSY never stall
  function automatic int expected_waits(input xfer_t e);
    if (e.err) begin
      return 1;
    end
    if (!e.trans[1]) begin
      return 0;
    end
    return e.prot ? `AHB_MEM_DATA_WAIT : `AHB_MEM_INSTR_WAIT;
  endfunction

  // Bytes of a transfer sit on the lanes given by their own address
  function automatic void model_write(input logic [31:0] a, input logic [2:0] sz,
                                      input logic [63:0] d);
    int n;
    int base;
    n = 1 << sz;
    base = int'(a) & ~(n - 1);
    for (int i = 0; i < n; i++) begin
      model[base + i] = d[((base + i) % 8) * 8 +: 8];
    end
  endfunction

  function automatic logic [63:0] model_read(input logic [31:0] a);
    logic [63:0] w;
    for (int i = 0; i < 8; i++) begin
      w[i*8 +: 8] = model[int'(a) + i];
    end
    return w;
  endfunction

  task automatic load_table();
    //       trans   write addr           size   prot write data  expected read data  error
    add_xfer(IDLE,   RD, 32'h0000_0000, DWORD, DAT, 64'h0, 64'h0, NOERR);
    add_xfer(NONSEQ, WR, 32'h0000_0000, DWORD, DAT, 64'h0706_0504_0302_0100, 64'h0, NOERR);
    add_xfer(SEQ,    WR, 32'h0000_0004, WORD,  DAT, 64'h1122_3344_ffff_ffff, 64'h0, NOERR);
    add_xfer(SEQ,    WR, 32'h0000_0006, HALF,  DAT, 64'hbbcc_ffff_ffff_ffff, 64'h0, NOERR);
    add_xfer(NONSEQ, WR, 32'h0000_0001, BYTE,  DAT, 64'hffff_ffff_ffff_aaff, 64'h0, NOERR);
    add_xfer(NONSEQ, RD, 32'h0000_0000, DWORD, DAT, 64'h0, 64'hbbcc_3344_0302_aa00, NOERR);
    // Same index in the other three banks
    add_xfer(NONSEQ, WR, 32'h0000_0200, DWORD, DAT, 64'h1111_1111_1111_1111, 64'h0, NOERR);
    add_xfer(NONSEQ, WR, 32'h0000_0400, DWORD, INS, 64'h2222_2222_2222_2222, 64'h0, NOERR);
    add_xfer(NONSEQ, WR, 32'h0000_0600, DWORD, DAT, 64'h3333_3333_3333_3333, 64'h0, NOERR);
    add_xfer(IDLE,   RD, 32'h0000_0600, DWORD, DAT, 64'h0, 64'h0, NOERR);
    add_xfer(NONSEQ, RD, 32'h0000_0000, DWORD, INS, 64'h0, 64'hbbcc_3344_0302_aa00, NOERR);
    add_xfer(NONSEQ, RD, 32'h0000_0200, DWORD, DAT, 64'h0, 64'h1111_1111_1111_1111, NOERR);
    add_xfer(NONSEQ, RD, 32'h0000_0400, DWORD, INS, 64'h0, 64'h2222_2222_2222_2222, NOERR);
    add_xfer(NONSEQ, RD, 32'h0000_0600, DWORD, DAT, 64'h0, 64'h3333_3333_3333_3333, NOERR);
    add_xfer(NONSEQ, WR, 32'h0000_0228, DWORD, DAT, 64'hdead_beef_cafe_f00d, 64'h0, NOERR);
    add_xfer(NONSEQ, WR, 32'h0000_022a, HALF,  DAT, 64'hffff_ffff_1234_ffff, 64'h0, NOERR);
    add_xfer(NONSEQ, WR, 32'h0000_022f, BYTE,  INS, 64'h99ff_ffff_ffff_ffff, 64'h0, NOERR);
    add_xfer(NONSEQ, RD, 32'h0000_0228, DWORD, INS, 64'h0, 64'h99ad_beef_1234_f00d, NOERR);
    // Outside the memory; 0x1000 would alias word 0 if the upper field were ignored
    add_xfer(NONSEQ, WR, 32'h0000_1000, DWORD, DAT, 64'h5555_5555_5555_5555, 64'h0, ERR);
    add_xfer(NONSEQ, RD, 32'h0000_0800, DWORD, DAT, 64'h0, 64'h0, ERR);
    add_xfer(NONSEQ, RD, 32'hffff_fff8, DWORD, INS, 64'h0, 64'h0, ERR);
    add_xfer(NONSEQ, RD, 32'h0000_0000, DWORD, DAT, 64'h0, 64'hbbcc_3344_0302_aa00, NOERR);
    add_xfer(NONSEQ, RD, 32'h0000_0228, DWORD, DAT, 64'h0, 64'h99ad_beef_1234_f00d, NOERR);
  endtask

  task automatic build_sweep();
    logic [31:0] r;
    logic [31:0] a;
    logic [63:0] d;
    logic [2:0]  sz;
    for (int w = 0; w < WORDS; w++) begin
      a = 32'(w) << 3;
      d = {$random(seed), $random(seed)};
      model_write(a, DWORD, d);
      add_xfer(NONSEQ, WR, a, DWORD, DAT, d, 64'h0, NOERR);
    end
    // One narrower write of random size and offset into every word
    for (int w = 0; w < WORDS; w++) begin
      r  = $random(seed);
      sz = {1'b0, r[1:0]};
      a  = (32'(w) << 3) | {29'h0, r[4:2]};
      a  = a & ~((32'h1 << sz) - 32'h1);
      d  = {$random(seed), $random(seed)};
      model_write(a, sz, d);
      add_xfer(SEQ, WR, a, sz, r[5], d, 64'h0, NOERR);
    end
    for (int w = 0; w < WORDS; w++) begin
      r = $random(seed);
      a = 32'(w) << 3;
      add_xfer(NONSEQ, RD, a, DWORD, r[0], 64'h0, model_read(a), NOERR);
    end
  endtask

  // Pipelined driver: the next address phase overlaps the current data phase
  task automatic run_xfers();
    int    a;
    int    d;
    int    waits;
    xfer_t e;
    a = 0;
    d = -1;
    waits = 0;
    while (a < xfers.size() || d >= 0) begin
      if (a < xfers.size()) begin
        e = xfers[a];
        hsel   <= 1'b1;
        haddr  <= e.addr;
        htrans <= e.trans;
        hsize  <= e.size;
        hwrite <= e.write;
        hprot  <= {3'b001, e.prot};
      end else begin
        htrans <= IDLE;
        hwrite <= 1'b0;
      end
      if (d >= 0) begin
        hwdata <= xfers[d].wdata;
      end
      @(negedge HCLK);
      if (d < 0) begin
        check(64'(hreadyout), 64'h1, "HREADYOUT with no transfer in progress");
      end else begin
        e = xfers[d];
        check(64'(hresp), 64'(e.err), $sformatf("entry %0d HRESP", d));
        if (!hreadyout) begin
          waits++;
        end else begin
          check(64'(waits), 64'(expected_waits(e)), $sformatf("entry %0d wait states", d));
          if (e.trans[1] && !e.write && !e.err) begin
            check(hrdata, e.rdata, $sformatf("entry %0d read data", d));
          end
        end
      end
      if (hreadyout) begin
        d = (a < xfers.size()) ? a : -1;
        if (a < xfers.size()) begin
          a++;
        end
        waits = 0;
      end
      @(posedge HCLK);
    end
  endtask

  initial begin
    HRESETn = 1'b0;
    hsel    = 1'b0;
    haddr   = 32'h0;
    htrans  = IDLE;
    hsize   = DWORD;
    hwrite  = 1'b0;
    hprot   = 4'b0011;
    hwdata  = 64'h0;
    seed    = SEED;
    load_table();
    build_sweep();
    // Each transfer needs at most W+1 cycles, two more leave some margin
    cycle_limit = xfers.size() * (`AHB_MEM_DATA_WAIT + 3) + 8;
    repeat (8) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    check(64'(hreadyout), 64'h1, "HREADYOUT after reset");
    check(64'(hresp), 64'h0, "HRESP after reset");
    @(posedge HCLK);
    run_xfers();
    @(negedge HCLK);
    if (dut0.chk0.fail_cnt != 0) begin
      $display("Protocol assertion failed in the bound checker before the end");
      $display("Something failed");
      $fatal(1, "Stopped on an assertion failure");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule
